//--- hw/uart_pkg.sv
package uart_pkg;

	localparam int BIT_COUNT = 8; // data bits per frame

	typedef logic [BIT_COUNT-1:0] byte_t; // one serial data byte

	typedef logic [$clog2(BIT_COUNT)-1:0] bit_index_t; // position inside the data bits

endpackage

//--- hw/station_pkg.sv
package station_pkg;

	import uart_pkg::*;

	// host command codes, ascii digits
	localparam byte_t CMD_STATUS     = 8'h30; // '0' sensor status query
	localparam byte_t CMD_TEMP       = 8'h31; // '1' single temperature
	localparam byte_t CMD_HUMID      = 8'h32; // '2' single humidity
	localparam byte_t CMD_CONT_TEMP  = 8'h33; // '3' continuous temperature
	localparam byte_t CMD_CONT_HUMID = 8'h34; // '4' continuous humidity
	localparam byte_t CMD_STOP_TEMP  = 8'h35; // '5' stop continuous temperature
	localparam byte_t CMD_STOP_HUMID = 8'h36; // '6' stop continuous humidity

	// first reply byte
	localparam byte_t RPL_STATUS_OK    = 8'h07;
	localparam byte_t RPL_STATUS_FAULT = 8'h1F;
	localparam byte_t RPL_HUMID        = 8'h08;
	localparam byte_t RPL_TEMP         = 8'h09;
	localparam byte_t RPL_CONT         = 8'hFD; // both continuous modes
	localparam byte_t RPL_STOP_TEMP    = 8'h0E;
	localparam byte_t RPL_STOP_HUMID   = 8'h0B;
	localparam byte_t RPL_INVALID      = 8'hFB;
	localparam byte_t RPL_FILLER       = 8'hFC; // second byte when no reading goes along

	localparam byte_t SENSOR_FAULT_DATA = 8'hFF; // status reading of a broken sensor

	typedef logic [1:0] sensor_kind_t; // what the sensor side is asked for

	localparam sensor_kind_t KIND_HUMID  = 2'd0;
	localparam sensor_kind_t KIND_TEMP   = 2'd1;
	localparam sensor_kind_t KIND_STATUS = 2'd2;

	typedef enum logic [2:0]
	{
		ST_IDLE,        // waiting for a pending command
		ST_DECODE,      // address and code check
		ST_SENSE,       // sensor request outstanding
		ST_FIRST,       // start the reply code byte
		ST_WAIT_FIRST,  // reply code on the line
		ST_SECOND,      // start the data or filler byte
		ST_WAIT_SECOND, // second byte on the line
		ST_INTERVAL     // continuous mode pause
	} seq_state_t;

endpackage

//--- hw/uart_receiver.sv
module uart_receiver import uart_pkg::*; #(
	parameter int CLKS_PER_BIT = 16
) (
	input  logic  clock,
	input  logic  reset,
	input  logic  rx_serial,
	output byte_t rx_byte,
	output logic  rx_done
);

	localparam int CW   = $clog2(CLKS_PER_BIT + 1);
	localparam int HALF = CLKS_PER_BIT / 2;

	typedef enum logic [2:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP, RX_TAIL} rx_state_t;

	rx_state_t  state;
	logic [CW-1:0] tick; // clocks inside the current bit
	bit_index_t bit_index;
	logic       rx_meta, rx_line; // two stage synchronizer
	logic       stop_ok; // stop bit seen high
	logic       bit_end, half_end;

	assign bit_end  = (tick == CW'(CLKS_PER_BIT - 1));
	assign half_end = (tick == CW'(HALF - 1));

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			rx_meta <= 1'b1; // line idles high
			rx_line <= 1'b1;
		end
		else
		begin
			rx_meta <= rx_serial;
			rx_line <= rx_meta;
		end
	end

	always_ff @(posedge clock)
	begin
		rx_done <= 1'b0; // pulse by default low
		if (reset)
		begin
			state     <= RX_IDLE;
			tick      <= '0;
			bit_index <= '0;
			stop_ok   <= 1'b0;
		end
		else
		begin
			tick <= tick + 1'b1;
			case (state)
				RX_IDLE:
				begin
					tick      <= '0;
					bit_index <= '0;
					if (!rx_line)
						state <= RX_START; // falling edge, maybe a start bit
				end
				RX_START:
				if (half_end)
				begin
					tick  <= '0;
					state <= rx_line ? RX_IDLE : RX_DATA; // glitch, not a start bit
				end
				RX_DATA:
				if (bit_end)
				begin
					tick      <= '0;
					bit_index <= bit_index + 1'b1;
					if (bit_index == bit_index_t'(BIT_COUNT - 1))
						state <= RX_STOP;
				end
				RX_STOP:
				if (bit_end)
				begin
					tick    <= '0;
					stop_ok <= rx_line; // mid stop bit sample
					state   <= RX_TAIL;
				end
				RX_TAIL:
				if (half_end)
				begin
					rx_done <= stop_ok; // framing error drops the byte
					state   <= RX_IDLE;
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

	always_ff @(posedge clock)
	begin
		if (state == RX_DATA && bit_end)
			rx_byte <= {rx_line, rx_byte[BIT_COUNT-1:1]}; // lsb arrives first
	end

endmodule

//--- hw/uart_transmitter.sv
module uart_transmitter import uart_pkg::*; #(
	parameter int CLKS_PER_BIT = 16
) (
	input  logic  clock,
	input  logic  reset,
	input  logic  tx_start,
	input  byte_t tx_byte,
	output logic  tx_serial,
	output logic  tx_busy,
	output logic  tx_done
);

	localparam int CW = $clog2(CLKS_PER_BIT + 1);

	typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;

	tx_state_t     state;
	logic [CW-1:0] tick;
	bit_index_t    bit_index;
	byte_t         shift; // bits still to send
	logic          bit_end;

	assign bit_end = (tick == CW'(CLKS_PER_BIT - 1));
	assign tx_busy = (state != TX_IDLE);
	assign tx_done = (state == TX_STOP) && bit_end; // last clock of the stop bit

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state     <= TX_IDLE;
			tick      <= '0;
			bit_index <= '0;
			tx_serial <= 1'b1; // idle line
		end
		else
		begin
			tick <= bit_end ? '0 : tick + 1'b1;
			case (state)
				TX_IDLE:
				begin
					tick      <= '0;
					bit_index <= '0;
					if (tx_start)
					begin
						tx_serial <= 1'b0; // start bit
						state     <= TX_START;
					end
				end
				TX_START:
				if (bit_end)
				begin
					tx_serial <= shift[0];
					state     <= TX_DATA;
				end
				TX_DATA:
				if (bit_end)
				begin
					bit_index <= bit_index + 1'b1;
					if (bit_index == bit_index_t'(BIT_COUNT - 1))
					begin
						tx_serial <= 1'b1; // stop bit
						state     <= TX_STOP;
					end
					else
						tx_serial <= shift[1]; // next bit, shift moves on this edge
				end
				TX_STOP:
				if (bit_end)
					state <= TX_IDLE;
				default: state <= TX_IDLE;
			endcase
		end
	end

	always_ff @(posedge clock)
	begin
		if (state == TX_IDLE && tx_start)
			shift <= tx_byte;
		else if (state == TX_DATA && bit_end)
			shift <= shift >> 1; // drop the bit just finished
	end

endmodule

//--- hw/command_framer.sv
module command_framer import uart_pkg::*; (
	input  logic  clock,
	input  logic  reset,
	input  logic  rx_done,
	input  byte_t rx_byte,
	input  logic  cmd_take,
	output byte_t cmd_code,
	output byte_t cmd_address,
	output logic  cmd_pending
);

	logic  second_slot; // next byte is the address
	byte_t code_hold; // code byte of the pair in progress
	logic  pair_done;

	assign pair_done = rx_done && second_slot;

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			second_slot <= 1'b0;
			cmd_pending <= 1'b0;
		end
		else
		begin
			if (rx_done)
				second_slot <= !second_slot; // alternate code and address
			if (pair_done)
				cmd_pending <= 1'b1; // a new pair wins over a take in the same cycle
			else if (cmd_take)
				cmd_pending <= 1'b0;
		end
	end

	always_ff @(posedge clock)
	begin
		if (rx_done && !second_slot)
			code_hold <= rx_byte;
		if (pair_done)
		begin
			cmd_code    <= code_hold; // overwrites an untaken command
			cmd_address <= rx_byte;
		end
	end

endmodule

//--- hw/reply_sequencer.sv
module reply_sequencer import uart_pkg::*, station_pkg::*; #(
	parameter int    INTERVAL_CYCLES = 1000,
	parameter byte_t STATION_ADDRESS = 8'h00
) (
	input  logic         clock,
	input  logic         reset,
	input  byte_t        cmd_code,
	input  byte_t        cmd_address,
	input  logic         cmd_pending,
	input  logic         tx_busy,
	input  logic         tx_done,
	input  logic         sensor_done,
	input  byte_t        sensor_data,
	output logic         cmd_take,
	output logic         tx_start,
	output byte_t        tx_byte,
	output logic         sensor_start,
	output sensor_kind_t sensor_kind
);

	localparam int IW = $clog2(INTERVAL_CYCLES + 1);

	seq_state_t    state;
	byte_t         code_q, address_q; // command being served
	byte_t         reply_code; // first reply byte
	byte_t         reply_data; // reading or filler
	logic          cont_mode;
	logic [IW-1:0] interval_count;
	logic          interval_end;

	assign interval_end = (interval_count == IW'(INTERVAL_CYCLES - 1));

	always_ff @(posedge clock)
	begin
		if (state == ST_IDLE && cmd_pending)
		begin
			code_q    <= cmd_code;
			address_q <= cmd_address;
		end
	end

	always_ff @(posedge clock)
	begin
		cmd_take     <= 1'b0; // strobes low unless set below
		tx_start     <= 1'b0;
		sensor_start <= 1'b0;
		if (reset)
		begin
			state          <= ST_IDLE;
			cont_mode      <= 1'b0;
			interval_count <= '0;
			sensor_kind    <= KIND_STATUS;
		end
		else
		begin
			case (state)
				ST_IDLE:
				if (cmd_pending)
				begin
					cmd_take <= 1'b1; // framer slot freed next cycle
					state    <= ST_DECODE;
				end
				ST_DECODE:
				begin
					cont_mode  <= 1'b0; // any command ends continuous mode
					reply_data <= RPL_FILLER;
					if (address_q != STATION_ADDRESS)
					begin
						reply_code <= RPL_INVALID; // wrong station, status included
						state      <= ST_FIRST;
					end
					else
					begin
						case (code_q)
							CMD_STATUS:
							begin
								sensor_kind  <= KIND_STATUS;
								sensor_start <= 1'b1;
								state        <= ST_SENSE;
							end
							CMD_TEMP, CMD_CONT_TEMP:
							begin
								sensor_kind  <= KIND_TEMP;
								sensor_start <= 1'b1;
								reply_code   <= (code_q == CMD_TEMP) ? RPL_TEMP : RPL_CONT;
								cont_mode    <= (code_q == CMD_CONT_TEMP);
								state        <= ST_SENSE;
							end
							CMD_HUMID, CMD_CONT_HUMID:
							begin
								sensor_kind  <= KIND_HUMID;
								sensor_start <= 1'b1;
								reply_code   <= (code_q == CMD_HUMID) ? RPL_HUMID : RPL_CONT;
								cont_mode    <= (code_q == CMD_CONT_HUMID);
								state        <= ST_SENSE;
							end
							CMD_STOP_TEMP:
							begin
								reply_code <= RPL_STOP_TEMP;
								state      <= ST_FIRST;
							end
							CMD_STOP_HUMID:
							begin
								reply_code <= RPL_STOP_HUMID;
								state      <= ST_FIRST;
							end
							default:
							begin
								reply_code <= RPL_INVALID; // unknown or binary code
								state      <= ST_FIRST;
							end
						endcase
					end
				end
				ST_SENSE:
				if (sensor_done)
				begin
					if (sensor_kind == KIND_STATUS)
					begin
						reply_code <= (sensor_data == SENSOR_FAULT_DATA) ?
							RPL_STATUS_FAULT : RPL_STATUS_OK;
						reply_data <= RPL_FILLER;
					end
					else
						reply_data <= sensor_data; // reading goes out as second byte
					state <= ST_FIRST;
				end
				ST_FIRST:
				if (!tx_busy)
				begin
					tx_byte  <= reply_code;
					tx_start <= 1'b1;
					state    <= ST_WAIT_FIRST;
				end
				ST_WAIT_FIRST:
				if (tx_done)
					state <= ST_SECOND;
				ST_SECOND:
				if (!tx_busy)
				begin
					tx_byte  <= reply_data;
					tx_start <= 1'b1;
					state    <= ST_WAIT_SECOND;
				end
				ST_WAIT_SECOND:
				if (tx_done)
				begin
					interval_count <= '0;
					state          <= cont_mode ? ST_INTERVAL : ST_IDLE;
				end
				ST_INTERVAL:
				if (cmd_pending)
				begin
					cont_mode <= 1'b0; // new host command takes over
					state     <= ST_IDLE;
				end
				else if (interval_end)
				begin
					sensor_start <= 1'b1; // next reading, kind still held
					state        <= ST_SENSE;
				end
				else
					interval_count <= interval_count + 1'b1;
				default: state <= ST_IDLE;
			endcase
		end
	end

endmodule

//--- hw/sensor_station.sv
module sensor_station import uart_pkg::*, station_pkg::*; #(
	parameter int    CLKS_PER_BIT    = 16,
	parameter int    INTERVAL_CYCLES = 1000,
	parameter byte_t STATION_ADDRESS = 8'h00
) (
	input  logic         clock,
	input  logic         reset,
	input  logic         rx_serial,
	input  logic         sensor_done,
	input  byte_t        sensor_data,
	output logic         tx_serial,
	output logic         sensor_start,
	output sensor_kind_t sensor_kind
);

	byte_t rx_byte, cmd_code, cmd_address, tx_byte;
	logic  rx_done, cmd_pending, cmd_take;
	logic  tx_start, tx_busy, tx_done;

	uart_receiver #(.CLKS_PER_BIT(CLKS_PER_BIT)) receiver0 (
		.clock(clock), .reset(reset), .rx_serial(rx_serial),
		.rx_byte(rx_byte), .rx_done(rx_done)
	);

	command_framer framer0 (
		.clock(clock), .reset(reset), .rx_done(rx_done), .rx_byte(rx_byte),
		.cmd_take(cmd_take), .cmd_code(cmd_code), .cmd_address(cmd_address),
		.cmd_pending(cmd_pending)
	);

	reply_sequencer #(
		.INTERVAL_CYCLES(INTERVAL_CYCLES), .STATION_ADDRESS(STATION_ADDRESS)
	) sequencer0 (
		.clock(clock), .reset(reset), .cmd_code(cmd_code), .cmd_address(cmd_address),
		.cmd_pending(cmd_pending), .tx_busy(tx_busy), .tx_done(tx_done),
		.sensor_done(sensor_done), .sensor_data(sensor_data), .cmd_take(cmd_take),
		.tx_start(tx_start), .tx_byte(tx_byte), .sensor_start(sensor_start),
		.sensor_kind(sensor_kind)
	);

	uart_transmitter #(.CLKS_PER_BIT(CLKS_PER_BIT)) transmitter0 (
		.clock(clock), .reset(reset), .tx_start(tx_start), .tx_byte(tx_byte),
		.tx_serial(tx_serial), .tx_busy(tx_busy), .tx_done(tx_done)
	);

endmodule

//--- bench/clock_gen.sv
module clock_gen #(
	parameter int HALF_PERIOD  = 10,
	parameter int RESET_CYCLES = 16
) (
	output logic clock,
	output logic reset
);

	timeunit 1ns;
	timeprecision 100ps;

	initial
	begin
		clock = 1'b0;
		forever
			#(HALF_PERIOD) clock = ~clock; // 20 ns period
	end

	initial
	begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clock);
		@(negedge clock);
		reset = 1'b0; // released on a falling edge like the other inputs
	end

endmodule

//--- bench/reply_monitor.sv
module reply_monitor import uart_pkg::*, station_pkg::*; #(
	parameter int CLKS_PER_BIT = 16
) (
	input  logic         clock,
	input  logic         reset,
	input  logic         tx_serial,
	input  logic         sensor_start,
	input  sensor_kind_t sensor_kind,
	input  logic         row_begin, // clears the per row counts
	input  logic         row_end, // compares the per row counts
	input  byte_t        expect_first,
	input  byte_t        expect_second,
	input  sensor_kind_t expect_kind,
	input  int           expect_pairs,
	input  int           expect_requests,
	output int           pair_count,
	output int           error_count
);

	timeunit 1ns;
	timeprecision 100ps;

	int    pairs_seen = 0; // all pairs since the start of the run
	int    pair_base = 0;
	int    requests_seen = 0;
	int    request_base = 0;
	int    reply_errors = 0; // wrong bytes and framing
	int    row_errors = 0; // counts and sensor kind
	logic  second_byte = 1'b0; // next byte closes a pair
	byte_t value;
	byte_t expected;

	assign pair_count  = pairs_seen - pair_base;
	assign error_count = reply_errors + row_errors;

	initial
	begin
		forever
		begin
			@(posedge clock);
			if (!reset && !tx_serial)
			begin
				repeat (CLKS_PER_BIT / 2) @(posedge clock); // middle of the start bit
				for (int i = 0; i < BIT_COUNT; i++)
				begin
					repeat (CLKS_PER_BIT) @(posedge clock);
					value[i] = tx_serial; // lsb first
				end
				repeat (CLKS_PER_BIT) @(posedge clock); // middle of the stop bit
				if (!tx_serial)
				begin
					$display("error @ %0t: reply byte %h has a low stop bit", $time, value);
					reply_errors++;
				end
				expected = second_byte ? expect_second : expect_first;
				if (value !== expected)
				begin
					$display("error @ %0t: reply byte %0d of pair %0d is %h, expected %h",
						$time, second_byte + 1, pair_count + 1, value, expected);
					reply_errors++;
				end
				if (second_byte)
					pairs_seen <= pairs_seen + 1; // seen by the row check one edge later
				second_byte = !second_byte;
			end
		end
	end

	always @(posedge clock)
	begin
		if (row_begin)
		begin
			pair_base    <= pairs_seen;
			request_base <= requests_seen;
		end
		if (!reset && sensor_start)
		begin
			requests_seen <= requests_seen + 1;
			if (sensor_kind !== expect_kind)
			begin
				$display("error @ %0t: sensor_kind %0d on request, expected %0d",
					$time, sensor_kind, expect_kind);
				row_errors++;
			end
		end
		if (row_end)
		begin
			if (pair_count != expect_pairs)
			begin
				$display("error @ %0t: %0d reply pairs in the row, expected %0d",
					$time, pair_count, expect_pairs);
				row_errors++;
			end
			if (requests_seen - request_base != expect_requests)
			begin
				$display("error @ %0t: %0d sensor requests in the row, expected %0d",
					$time, requests_seen - request_base, expect_requests);
				row_errors++;
			end
		end
	end

endmodule

//--- bench/station_chk.sv
module station_chk import station_pkg::*; (
	input logic         clock,
	input logic         reset,
	input logic         sensor_start,
	input logic         sensor_done,
	input sensor_kind_t sensor_kind,
	input logic         tx_start,
	input logic         tx_busy
);

	timeunit 1ns;
	timeprecision 100ps;

	int           failures = 0;
	logic         request_open; // sensor request not yet answered
	sensor_kind_t kind_at_start;

	always_ff @(posedge clock)
	begin
		if (reset)
			request_open <= 1'b0;
		else if (sensor_start)
		begin
			request_open  <= 1'b1;
			kind_at_start <= sensor_kind; // kind is set on the same edge as the strobe
		end
		else if (sensor_done)
			request_open <= 1'b0;
	end

	start_single: assert property (@(posedge clock) disable iff (reset)
		sensor_start |=> !sensor_start)
	else
	begin
		$error("sensor_start lasted more than one cycle");
		failures++;
	end

	start_when_idle: assert property (@(posedge clock) disable iff (reset)
		tx_start |-> !tx_busy)
	else
	begin
		$error("tx_start raised while the transmitter is busy");
		failures++;
	end

	kind_held: assert property (@(posedge clock) disable iff (reset)
		request_open |-> sensor_kind == kind_at_start)
	else
	begin
		$error("sensor_kind changed before sensor_done");
		failures++;
	end

endmodule

//--- bench/station_tb.sv
module station_tb import uart_pkg::*, station_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int    CLKS_PER_BIT     = 8;
	localparam int    INTERVAL_CYCLES  = 400;
	localparam byte_t STATION_ADDRESS  = 8'h00;
	localparam int    FRAME_CYCLES     = 10 * CLKS_PER_BIT;
	localparam int    MAX_SENSOR_DELAY = 60;
	localparam int    ROW_BUDGET = 4 * FRAME_CYCLES + MAX_SENSOR_DELAY + 2 * INTERVAL_CYCLES;

	typedef struct packed {
		byte_t        code;
		byte_t        address;
		byte_t        data; // what the sensor model returns
		int           pairs; // reply pairs to wait for
		int           requests; // sensor requests in the row
		byte_t        first;
		byte_t        second;
		sensor_kind_t kind;
		logic         quiet; // no pair may follow for two intervals
	} row_t;

	logic         clock, reset;
	logic         rx_serial, sensor_done, tx_serial, sensor_start;
	byte_t        sensor_data;
	sensor_kind_t sensor_kind;
	logic         row_begin, row_end;
	int           pair_count, monitor_errors;
	row_t         rows[$];
	row_t         row; // row being applied
	int           cycles = 0;
	int           timeout_limit = 0;

	clock_gen #(.HALF_PERIOD(10), .RESET_CYCLES(16)) clock_gen0 (.clock(clock), .reset(reset));

	sensor_station #(
		.CLKS_PER_BIT(CLKS_PER_BIT), .INTERVAL_CYCLES(INTERVAL_CYCLES),
		.STATION_ADDRESS(STATION_ADDRESS)
	) dut0 (
		.clock(clock), .reset(reset), .rx_serial(rx_serial), .sensor_done(sensor_done),
		.sensor_data(sensor_data), .tx_serial(tx_serial), .sensor_start(sensor_start),
		.sensor_kind(sensor_kind)
	);

	reply_monitor #(.CLKS_PER_BIT(CLKS_PER_BIT)) monitor0 (
		.clock(clock), .reset(reset), .tx_serial(tx_serial), .sensor_start(sensor_start),
		.sensor_kind(sensor_kind), .row_begin(row_begin), .row_end(row_end),
		.expect_first(row.first), .expect_second(row.second), .expect_kind(row.kind),
		.expect_pairs(row.pairs), .expect_requests(row.requests),
		.pair_count(pair_count), .error_count(monitor_errors)
	);

	bind reply_sequencer station_chk chk0 (
		.clock(clock), .reset(reset), .sensor_start(sensor_start),
		.sensor_done(sensor_done), .sensor_kind(sensor_kind),
		.tx_start(tx_start), .tx_busy(tx_busy)
	);

	task automatic add_row(input byte_t code, address, data, input int pairs, requests,
		input byte_t first, second, input sensor_kind_t kind, input logic quiet);
		rows.push_back('{code, address, data, pairs, requests, first, second, kind, quiet});
	endtask

	task automatic send_byte(input byte_t value);
		rx_serial = 1'b0; // start bit
		repeat (CLKS_PER_BIT) @(negedge clock);
		for (int i = 0; i < BIT_COUNT; i++)
		begin
			rx_serial = value[i]; // lsb first
			repeat (CLKS_PER_BIT) @(negedge clock);
		end
		rx_serial = 1'b1; // stop bit and two idle bits
		repeat (3 * CLKS_PER_BIT) @(negedge clock);
	endtask

	task automatic report_counts();
		$display("errors: %0d reply or row mismatches, %0d assertion failures",
			monitor_errors, dut0.sequencer0.chk0.failures);
	endtask

	initial
	begin
		rx_serial = 1'b1; // idle line
		row_begin = 1'b0;
		row_end   = 1'b0;
		row       = '0;
		// code, address, data, pairs, requests, first, second, kind, quiet
		add_row(CMD_TEMP, 8'h00, 8'h19, 1, 1, RPL_TEMP, 8'h19, KIND_TEMP, 1'b0);
		add_row(CMD_HUMID, 8'h00, 8'h2D, 1, 1, RPL_HUMID, 8'h2D, KIND_HUMID, 1'b0);
		add_row(CMD_STATUS, 8'h00, SENSOR_FAULT_DATA, 1, 1, RPL_STATUS_FAULT, RPL_FILLER,
			KIND_STATUS, 1'b0);
		add_row(CMD_STATUS, 8'h00, 8'h42, 1, 1, RPL_STATUS_OK, RPL_FILLER, KIND_STATUS, 1'b0);
		add_row(8'h37, 8'h00, 8'h00, 1, 0, RPL_INVALID, RPL_FILLER, KIND_STATUS, 1'b0); // '7'
		add_row(8'h01, 8'h00, 8'h00, 1, 0, RPL_INVALID, RPL_FILLER, KIND_STATUS, 1'b0); // binary
		add_row(CMD_TEMP, 8'h05, 8'h19, 1, 0, RPL_INVALID, RPL_FILLER, KIND_TEMP, 1'b0);
		add_row(CMD_STATUS, 8'h01, 8'h42, 1, 0, RPL_INVALID, RPL_FILLER, KIND_STATUS, 1'b0);
		add_row(CMD_CONT_TEMP, 8'h00, 8'h17, 2, 2, RPL_CONT, 8'h17, KIND_TEMP, 1'b0);
		add_row(CMD_STOP_TEMP, 8'h00, 8'h00, 1, 0, RPL_STOP_TEMP, RPL_FILLER, KIND_TEMP, 1'b1);
		add_row(CMD_CONT_HUMID, 8'h00, 8'h38, 2, 2, RPL_CONT, 8'h38, KIND_HUMID, 1'b0);
		add_row(CMD_STOP_HUMID, 8'h00, 8'h00, 1, 0, RPL_STOP_HUMID, RPL_FILLER, KIND_HUMID,
			1'b1);
		timeout_limit = rows.size() * ROW_BUDGET * 2;
		@(negedge reset);
		repeat (4) @(negedge clock);
		foreach (rows[i])
		begin
			row       = rows[i];
			row_begin = 1'b1;
			@(negedge clock);
			row_begin = 1'b0;
			send_byte(row.code);
			send_byte(row.address);
			while (pair_count < row.pairs)
				@(negedge clock); // continuous rows wait for two pairs
			if (row.quiet)
				repeat (2 * INTERVAL_CYCLES) @(negedge clock); // repeats must have stopped
			row_end = 1'b1;
			@(negedge clock);
			row_end = 1'b0;
			@(negedge clock);
		end
		report_counts();
		if (monitor_errors == 0 && dut0.sequencer0.chk0.failures == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

	initial
	begin
		int delay;
		void'($urandom(18983));
		sensor_done = 1'b0;
		sensor_data = '0;
		forever
		begin
			@(negedge clock);
			if (sensor_start)
			begin
				delay = $urandom_range(MAX_SENSOR_DELAY, 5);
				repeat (delay) @(negedge clock);
				sensor_data = row.data;
				sensor_done = 1'b1; // one cycle pulse
				@(negedge clock);
				sensor_done = 1'b0;
			end
		end
	end

	initial
	begin
		wait (timeout_limit > 0);
		while (cycles < timeout_limit)
		begin
			@(posedge clock);
			cycles++;
		end
		$display("run timed out after %0d cycles before all rows got their replies", cycles);
		report_counts();
		$display("=== FAIL ===");
		$finish;
	end

endmodule

//--- all.f
hw/uart_pkg.sv
hw/station_pkg.sv
hw/uart_receiver.sv
hw/uart_transmitter.sv
hw/command_framer.sv
hw/reply_sequencer.sv
hw/sensor_station.sv
bench/clock_gen.sv
bench/reply_monitor.sv
bench/station_chk.sv
bench/station_tb.sv

//--- Bender.yml
package:
  name: sensor_station

sources:
  - hw/uart_pkg.sv
  - hw/station_pkg.sv
  - hw/uart_receiver.sv
  - hw/uart_transmitter.sv
  - hw/command_framer.sv
  - hw/reply_sequencer.sv
  - hw/sensor_station.sv
  - target: test
    files:
      - bench/clock_gen.sv
      - bench/reply_monitor.sv
      - bench/station_chk.sv
      - bench/station_tb.sv
